// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuTb
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

// ==== build.f ====
+incdir+include
source/cpu_pkg.sv
source/registerFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/pipelineCpu.sv
tests/cpu_sva.sv
tests/cpuTb.sv

// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address widths
`define CPU_XLEN            32
`define CPU_PC_WIDTH        32
`define CPU_REG_COUNT       32

// Data memory size in words and its index width
`define CPU_DMEM_DEPTH      256
`define CPU_DMEM_ADDR_WIDTH 8

// Primary opcodes
`define CPU_OP_RTYPE        6'h00
`define CPU_OP_J            6'h02
`define CPU_OP_BEQ          6'h04
`define CPU_OP_ADDI         6'h08
`define CPU_OP_LW           6'h23
`define CPU_OP_SW           6'h2b

// R-type function codes
`define CPU_FN_ADD          6'h20
`define CPU_FN_SUB          6'h22
`define CPU_FN_AND          6'h24
`define CPU_FN_OR           6'h25
`define CPU_FN_SLT          6'h2a

// All ones stops the machine
`define CPU_HALT_WORD       32'hffff_ffff

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    // Basic vectors
    typedef logic [`CPU_XLEN-1:0]     word_t;
    typedef logic [`CPU_PC_WIDTH-1:0] pc_t;
    typedef logic [4:0]               regIdx_t;
    typedef logic [31:0]              instr_t;

    // ALU operation
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // Operand source picked by the forwarding logic
    typedef logic [1:0] fwdSel_t;
    localparam fwdSel_t fwdReg       = 2'd0;
    localparam fwdSel_t fwdExMem     = 2'd1;
    localparam fwdSel_t fwdMemWbAlu  = 2'd2;
    localparam fwdSel_t fwdMemWbLoad = 2'd3;

    // Decoded control word
    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   useImm;
        logic   branch;
        logic   halt;
        aluOp_t aluOp;
    } ctrl_t;

    // Pipeline registers
    typedef struct packed {
        logic   valid;
        instr_t instr;
        pc_t    pcNext;
    } ifIdReg_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t dest;
        word_t   rsVal;
        word_t   rtVal;
        word_t   imm;
        pc_t     pcNext;
    } idExReg_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        regIdx_t dest;
        word_t   aluResult;
        word_t   storeData;
    } exMemReg_t;

    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    memToReg;
        logic    halt;
        regIdx_t dest;
        word_t   aluResult;
        word_t   loadData;
    } memWbReg_t;

    // Observation ports
    typedef struct packed {
        logic    valid;
        regIdx_t dest;
        word_t   data;
    } wbPort_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } storePort_t;

endpackage

// ==== source/decodeStage.sv ====
`include "cpu_config.svh"

module decodeStage
    import cpu_pkg::*;
(
    input  logic     idex,
    input  logic     arstN,
    input  ifIdReg_t ifId,
    input  logic     stall,
    input  logic     flushIdEx,
    input  word_t    rsVal,
    input  word_t    rtVal,
    output regIdx_t  rsIdx,
    output regIdx_t  rtIdx,
    output idExReg_t idEx,
    output logic     jumpTaken,
    output pc_t      jumpTarget,
    output logic     halting
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdx_t    rdIdx;
    word_t      immExt;
    ctrl_t      ctrlD;
    regIdx_t    destD;
    logic       isHalt;
    logic       haltSeen;
    logic       loadIdEx;

    // Instruction fields
    assign opcode = ifId.instr[31:26];
    assign rsIdx  = ifId.instr[25:21];
    assign rtIdx  = ifId.instr[20:16];
    assign rdIdx  = ifId.instr[15:11];
    assign funct  = ifId.instr[5:0];
    assign immExt = {{(`CPU_XLEN-16){ifId.instr[15]}}, ifId.instr[15:0]};

    assign isHalt = ifId.valid && (ifId.instr == `CPU_HALT_WORD);

    // Jump keeps the top 4 bits of the next PC
    assign jumpTaken  = ifId.valid && !isHalt && (opcode == `CPU_OP_J);
    assign jumpTarget = {ifId.pcNext[31:28], 2'b00, ifId.instr[25:0]};

    // Control word from opcode and function code
    always_comb begin
        ctrlD       = '0;
        ctrlD.aluOp = aluAdd;
        destD       = rtIdx;
        if (isHalt) begin
            ctrlD.halt = 1'b1;
        end else begin
            case (opcode)
                `CPU_OP_RTYPE: begin
                    destD          = rdIdx;
                    ctrlD.regWrite = 1'b1;
                    case (funct)
                        `CPU_FN_ADD: ctrlD.aluOp = aluAdd;
                        `CPU_FN_SUB: ctrlD.aluOp = aluSub;
                        `CPU_FN_AND: ctrlD.aluOp = aluAnd;
                        `CPU_FN_OR:  ctrlD.aluOp = aluOr;
                        `CPU_FN_SLT: ctrlD.aluOp = aluSlt;
                        // Unknown function runs as a no-op
                        default:     ctrlD.regWrite = 1'b0;
                    endcase
                end
                `CPU_OP_ADDI: begin
                    ctrlD.regWrite = 1'b1;
                    ctrlD.useImm   = 1'b1;
                end
                `CPU_OP_LW: begin
                    ctrlD.regWrite = 1'b1;
                    ctrlD.memToReg = 1'b1;
                    ctrlD.useImm   = 1'b1;
                end
                `CPU_OP_SW: begin
                    ctrlD.memWrite = 1'b1;
                    ctrlD.useImm   = 1'b1;
                end
                `CPU_OP_BEQ: begin
                    ctrlD.branch = 1'b1;
                    ctrlD.aluOp  = aluSub;
                end
                default: ;
            endcase
        end
        // Register 0 is never a real destination
        if (destD == '0) begin
            ctrlD.regWrite = 1'b0;
        end
    end

    // Instruction moves on unless stalled or flushed
    assign loadIdEx = ifId.valid && !stall && !flushIdEx;

    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            haltSeen <= 1'b0;
        end else if (isHalt && loadIdEx) begin
            haltSeen <= 1'b1;
        end
    end

    assign halting = haltSeen | isHalt;

    // ID/EX register
    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx.valid  <= loadIdEx;
            idEx.ctrl   <= loadIdEx ? ctrlD : '0;
            idEx.rs     <= rsIdx;
            idEx.rt     <= rtIdx;
            idEx.dest   <= destD;
            idEx.rsVal  <= rsVal;
            idEx.rtVal  <= rtVal;
            idEx.imm    <= immExt;
            idEx.pcNext <= ifId.pcNext;
        end
    end

endmodule

// ==== source/executeStage.sv ====
module executeStage
    import cpu_pkg::*;
(
    input  logic      idex,
    input  logic      arstN,
    input  idExReg_t  idEx,
    input  fwdSel_t   fwdA,
    input  fwdSel_t   fwdB,
    input  word_t     exMemResult,
    input  word_t     memWbResult,
    input  word_t     memWbLoad,
    output exMemReg_t exMem,
    output logic      branchTaken,
    output pc_t       branchTarget
);

    word_t opA;
    word_t rtFwd;
    word_t opB;
    word_t aluResult;

    // Same mux for both operands
    function automatic word_t pickOperand(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   exMemVal,
        input word_t   wbAluVal,
        input word_t   wbLoadVal
    );
        word_t result;
        case (sel)
            fwdExMem:     result = exMemVal;
            fwdMemWbAlu:  result = wbAluVal;
            fwdMemWbLoad: result = wbLoadVal;
            default:      result = regVal;
        endcase
        return result;
    endfunction

    assign opA   = pickOperand(fwdA, idEx.rsVal, exMemResult, memWbResult, memWbLoad);
    assign rtFwd = pickOperand(fwdB, idEx.rtVal, exMemResult, memWbResult, memWbLoad);

    // Immediate replaces rt for addi, lw and sw
    assign opB = idEx.ctrl.useImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = ($signed(opA) < $signed(opB)) ? word_t'(1) : '0;
            default: aluResult = opA + opB;
        endcase
    end

    // beq compares the forwarded register values
    assign branchTaken  = idEx.valid && idEx.ctrl.branch && (opA == rtFwd);
    assign branchTarget = idEx.pcNext + idEx.imm;

    // EX/MEM register
    // A taken beq has nothing left to do so it leaves as a bubble
    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid && !branchTaken;
            exMem.ctrl      <= (idEx.valid && !branchTaken) ? idEx.ctrl : '0;
            exMem.dest      <= idEx.dest;
            exMem.aluResult <= aluResult;
            exMem.storeData <= rtFwd;
        end
    end

endmodule

// ==== source/fetchStage.sv ====
module fetchStage
    import cpu_pkg::*;
(
    input  logic     idex,
    input  logic     arstN,
    input  instr_t   instruction,
    input  logic     stall,
    input  logic     flushIfId,
    input  logic     halting,
    input  logic     jumpTaken,
    input  pc_t      jumpTarget,
    input  logic     branchTaken,
    input  pc_t      branchTarget,
    output pc_t      pc,
    output ifIdReg_t ifId
);

    pc_t pcNext;

    // Word addressed so the next sequential PC is just plus one
    assign pcNext = pc + 1'b1;

    // Branch wins, then jump, then sequential
    // Stall and halt freeze everything except a branch
    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall && !halting) begin
            if (jumpTaken) begin
                pc <= jumpTarget;
            end else begin
                pc <= pcNext;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else if (flushIfId) begin
            // Wrong path instruction dropped
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            // Only bubbles once the halt is seen
            ifId.valid  <= !halting;
            ifId.instr  <= instruction;
            ifId.pcNext <= pcNext;
        end
    end

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit
    import cpu_pkg::*;
(
    input  regIdx_t   ifIdRs,
    input  regIdx_t   ifIdRt,
    input  idExReg_t  idEx,
    input  exMemReg_t exMem,
    input  memWbReg_t memWb,
    input  logic      branchTaken,
    input  logic      jumpTaken,
    output logic      stall,
    output logic      flushIfId,
    output logic      flushIdEx,
    output fwdSel_t   fwdA,
    output fwdSel_t   fwdB
);

    logic loadUse;

    // EX/MEM is younger so it wins over MEM/WB
    function automatic fwdSel_t pickSource(
        input regIdx_t   src,
        input exMemReg_t em,
        input memWbReg_t mw
    );
        fwdSel_t sel;
        sel = fwdReg;
        if (src != '0) begin
            if (em.valid && em.ctrl.regWrite && em.dest == src) begin
                sel = fwdExMem;
            end else if (mw.valid && mw.regWrite && mw.dest == src) begin
                // Loaded data comes from its own MEM/WB field
                sel = mw.memToReg ? fwdMemWbLoad : fwdMemWbAlu;
            end
        end
        return sel;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

    // lw in ID/EX feeding the instruction right behind it
    assign loadUse = idEx.valid && idEx.ctrl.memToReg && idEx.ctrl.regWrite
                     && (idEx.dest == ifIdRs || idEx.dest == ifIdRt);

    // Taken branch kills everything younger so the stall is moot
    assign stall = loadUse && !branchTaken;

    // Jump waits in decode while a stall is pending
    assign flushIfId = branchTaken || (jumpTaken && !stall);
    assign flushIdEx = branchTaken;

endmodule

// ==== source/memoryStage.sv ====
`include "cpu_config.svh"

module memoryStage
    import cpu_pkg::*;
(
    input  logic       idex,
    input  logic       arstN,
    input  exMemReg_t  exMem,
    output storePort_t store,
    output memWbReg_t  memWb
);

    word_t                          dmem [`CPU_DMEM_DEPTH];
    logic [`CPU_DMEM_ADDR_WIDTH-1:0] dmemIdx;
    logic                           storeEn;
    word_t                          loadData;

    // Word index from the low address bits
    assign dmemIdx = exMem.aluResult[`CPU_DMEM_ADDR_WIDTH-1:0];
    assign storeEn = exMem.valid && exMem.ctrl.memWrite;

    // Store strobe in the cycle the memory is written
    assign store.valid = storeEn;
    assign store.addr  = exMem.aluResult;
    assign store.data  = exMem.storeData;

    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeEn) begin
            dmem[dmemIdx] <= exMem.storeData;
        end
    end

    // Asynchronous read
    assign loadData = dmem[dmemIdx];

    // MEM/WB register
    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else begin
            memWb.valid     <= exMem.valid;
            memWb.regWrite  <= exMem.valid && exMem.ctrl.regWrite;
            memWb.memToReg  <= exMem.ctrl.memToReg;
            memWb.halt      <= exMem.valid && exMem.ctrl.halt;
            memWb.dest      <= exMem.dest;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= loadData;
        end
    end

endmodule

// ==== source/pipelineCpu.sv ====
module pipelineCpu
    import cpu_pkg::*;
(
    input  logic       idex,
    input  logic       arstN,
    output pc_t        pc,
    input  instr_t     instruction,
    output wbPort_t    writeBack,
    output storePort_t store,
    output logic       halted
);

    // Stage registers
    ifIdReg_t  ifId;
    idExReg_t  idEx;
    exMemReg_t exMem;
    memWbReg_t memWb;

    // Register file read path
    regIdx_t rsIdx;
    regIdx_t rtIdx;
    word_t   rsVal;
    word_t   rtVal;

    // Redirects and hazard control
    logic    jumpTaken;
    pc_t     jumpTarget;
    logic    branchTaken;
    pc_t     branchTarget;
    logic    halting;
    logic    stall;
    logic    flushIfId;
    logic    flushIdEx;
    fwdSel_t fwdA;
    fwdSel_t fwdB;

    // Sticky once the halt word retires
    logic haltedQ;

    fetchStage uFetch (
        .idex(idex), .arstN(arstN), .instruction(instruction),
        .stall(stall), .flushIfId(flushIfId), .halting(halting),
        .jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .pc(pc), .ifId(ifId)
    );

    decodeStage uDecode (
        .idex(idex), .arstN(arstN), .ifId(ifId), .stall(stall),
        .flushIdEx(flushIdEx), .rsVal(rsVal), .rtVal(rtVal),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .idEx(idEx),
        .jumpTaken(jumpTaken), .jumpTarget(jumpTarget), .halting(halting)
    );

    registerFile uRegs (
        .idex(idex), .arstN(arstN), .rsIdx(rsIdx), .rtIdx(rtIdx),
        .memWb(memWb), .rsVal(rsVal), .rtVal(rtVal)
    );

    executeStage uExecute (
        .idex(idex), .arstN(arstN), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .exMemResult(exMem.aluResult), .memWbResult(memWb.aluResult),
        .memWbLoad(memWb.loadData), .exMem(exMem),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    memoryStage uMemory (
        .idex(idex), .arstN(arstN), .exMem(exMem), .store(store), .memWb(memWb)
    );

    hazardUnit uHazard (
        .ifIdRs(rsIdx), .ifIdRt(rtIdx), .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken), .stall(stall),
        .flushIfId(flushIfId), .flushIdEx(flushIdEx), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Retired register writes
    assign writeBack.valid = memWb.valid & memWb.regWrite;
    assign writeBack.dest  = memWb.dest;
    assign writeBack.data  = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            haltedQ <= 1'b0;
        end else if (memWb.valid && memWb.halt) begin
            haltedQ <= 1'b1;
        end
    end

    // High from the cycle the halt sits in MEM/WB
    assign halted = haltedQ | (memWb.valid & memWb.halt);

endmodule

// ==== source/registerFile.sv ====
`include "cpu_config.svh"

module registerFile
    import cpu_pkg::*;
(
    input  logic      idex,
    input  logic      arstN,
    input  regIdx_t   rsIdx,
    input  regIdx_t   rtIdx,
    input  memWbReg_t memWb,
    output word_t     rsVal,
    output word_t     rtVal
);

    word_t regs [`CPU_REG_COUNT];
    logic  wrEn;
    word_t wrData;

    // Write port fed from MEM/WB
    assign wrEn   = memWb.valid && memWb.regWrite && (memWb.dest != '0);
    assign wrData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    always_ff @(posedge idex or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[memWb.dest] <= wrData;
        end
    end

    // Same cycle write shows up on the read ports
    assign rsVal = (rsIdx == '0) ? '0 : (wrEn && memWb.dest == rsIdx) ? wrData : regs[rsIdx];
    assign rtVal = (rtIdx == '0) ? '0 : (wrEn && memWb.dest == rtIdx) ? wrData : regs[rtIdx];

endmodule

// ==== tests/cpuTb.sv ====
`include "cpu_config.svh"

module cpuTb
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Program sizes of all tests, for the watchdog
    localparam int instrTotal  = 91;
    localparam int testCount   = 6;
    localparam int cycleBudget = 40 * instrTotal + testCount * 24;

    logic       idex;
    logic       arstN;
    pc_t        pc;
    instr_t     instruction;
    wbPort_t    writeBack;
    storePort_t store;
    logic       halted;

    instr_t     prog[$];
    wbPort_t    expWb[$];
    storePort_t expSt[$];
    wbPort_t    wbExp;
    storePort_t stExp;
    logic       checking;
    int         errorCount;
    int         passCount;
    int         failCount;
    integer     seed = 26;

    pipelineCpu u_dut (
        .idex(idex), .arstN(arstN), .pc(pc), .instruction(instruction),
        .writeBack(writeBack), .store(store), .halted(halted)
    );

    initial begin
        idex = 1'b0;
        forever #4 idex = ~idex;
    end

    // Instruction memory, halt word past the end
    function automatic instr_t fetchWord(input pc_t addr);
        if (addr < pc_t'(prog.size())) begin
            return prog[addr];
        end
        return `CPU_HALT_WORD;
    endfunction

    initial begin
        instruction = `CPU_HALT_WORD;
        forever begin
            @(posedge idex);
            #1 instruction = fetchWord(pc);
        end
    end

    // Encoders
    function automatic instr_t rType(input logic [5:0] fn, input regIdx_t rd,
                                     input regIdx_t rs, input regIdx_t rt);
        return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t iType(input logic [5:0] op, input regIdx_t rt,
                                     input regIdx_t rs, input int imm);
        return {op, rs, rt, imm[15:0]};
    endfunction

    function automatic instr_t jType(input int target);
        return {`CPU_OP_J, target[25:0]};
    endfunction

    task automatic emit(input instr_t ins);
        prog.push_back(ins);
    endtask

    // Sequential ISA model, fills the expected strobe lists
    function automatic void runModel();
        word_t   regs [32];
        word_t   mem [256];
        pc_t     pcM;
        instr_t  ins;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        word_t   val;
        regIdx_t dst;
        logic    wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        expWb.delete();
        expSt.delete();
        pcM = '0;
        for (int step = 0; step < 4000; step++) begin
            ins = fetchWord(pcM);
            if (ins == `CPU_HALT_WORD) begin
                break;
            end
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            pcM  = pcM + 1;
            wr   = 1'b0;
            dst  = ins[20:16];
            val  = '0;
            case (ins[31:26])
                `CPU_OP_RTYPE: begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        `CPU_FN_ADD: val = a + b;
                        `CPU_FN_SUB: val = a - b;
                        `CPU_FN_AND: val = a & b;
                        `CPU_FN_OR:  val = a | b;
                        `CPU_FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:     wr = 1'b0;
                    endcase
                end
                `CPU_OP_ADDI: begin
                    wr  = 1'b1;
                    val = addr;
                end
                `CPU_OP_LW: begin
                    wr  = 1'b1;
                    val = mem[addr[7:0]];
                end
                `CPU_OP_SW: begin
                    mem[addr[7:0]] = b;
                    expSt.push_back({1'b1, addr, b});
                end
                // Targets relative to the next PC
                `CPU_OP_BEQ: if (a == b) pcM = pcM + imm;
                `CPU_OP_J:   pcM = {pcM[31:28], 2'b00, ins[25:0]};
                default: ;
            endcase
            // r0 writes are dropped
            if (wr && dst != '0) begin
                regs[dst] = val;
                expWb.push_back({1'b1, dst, val});
            end
        end
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    // Strobes sampled mid cycle, each one popped against the model
    always @(negedge idex) begin
        if (checking) begin
            if (halted && (writeBack.valid || store.valid)) begin
                $display("At %0d ns a strobe appeared after halted was raised", $time);
                errorCount++;
            end
            if (writeBack.valid) begin
                if (expWb.size() == 0) begin
                    $display("At %0d ns r%0d was written back but none was expected",
                             $time, writeBack.dest);
                    errorCount++;
                end else begin
                    wbExp = expWb.pop_front();
                    checkValue(32'(writeBack.dest), 32'(wbExp.dest), "write-back register");
                    checkValue(writeBack.data, wbExp.data, "write-back data");
                end
            end
            if (store.valid) begin
                if (expSt.size() == 0) begin
                    $display("At %0d ns a store to %0h appeared but none was expected",
                             $time, store.addr);
                    errorCount++;
                end else begin
                    stExp = expSt.pop_front();
                    checkValue(store.addr, stExp.addr, "store address");
                    checkValue(store.data, stExp.data, "store data");
                end
            end
        end
    end

    // Reset, run to halt, then watch halted for a few cycles
    task automatic runTest(input string name);
        int errorsBefore;
        errorsBefore = errorCount;
        checking = 1'b0;
        @(posedge idex);
        #1 arstN = 1'b0;
        repeat (16) @(posedge idex);
        // Reset state of the fetch port and the halt flag
        checkValue(pc, '0, "pc during reset");
        checkValue(32'(halted), 32'd0, "halted during reset");
        runModel();
        checking = 1'b1;
        #1 arstN = 1'b1;
        while (!halted) @(negedge idex);
        repeat (6) begin
            @(negedge idex);
            checkValue(32'(halted), 32'd1, "halted");
        end
        checkValue(expWb.size(), 0, "write-backs still missing");
        checkValue(expSt.size(), 0, "stores still missing");
        checking = 1'b0;
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic randomProgram();
        int      kind;
        int      imm;
        regIdx_t rd;
        regIdx_t rs;
        regIdx_t rt;
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            kind = {$random(seed)} % 8;
            rd   = regIdx_t'(1 + {$random(seed)} % 7);
            rs   = regIdx_t'(1 + {$random(seed)} % 7);
            rt   = regIdx_t'(1 + {$random(seed)} % 7);
            imm  = $random(seed) % 64;
            case (kind)
                0: emit(rType(`CPU_FN_ADD, rd, rs, rt));
                1: emit(rType(`CPU_FN_SUB, rd, rs, rt));
                2: emit(rType(`CPU_FN_AND, rd, rs, rt));
                3: emit(rType(`CPU_FN_OR, rd, rs, rt));
                4: emit(rType(`CPU_FN_SLT, rd, rs, rt));
                5: emit(iType(`CPU_OP_ADDI, rd, rs, imm));
                // Memory ops on a small window so loads see earlier stores
                6: emit(iType(`CPU_OP_LW, rd, 0, imm & 15));
                default: emit(iType(`CPU_OP_SW, rt, 0, imm & 15));
            endcase
        end
    endtask

    initial begin
        #(cycleBudget * 8);
        $display("Timeout: the tests did not finish within %0d cycles", cycleBudget);
        $display("sim failed");
        $finish;
    end

    initial begin
        arstN      = 1'b0;
        checking   = 1'b0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;

        // Dependent ALU chain
        prog.delete();
        emit(iType(`CPU_OP_ADDI, 1, 0, 5));
        emit(iType(`CPU_OP_ADDI, 2, 1, 3));
        emit(rType(`CPU_FN_ADD, 3, 1, 2));
        emit(rType(`CPU_FN_SUB, 4, 3, 1));
        emit(rType(`CPU_FN_AND, 5, 4, 3));
        emit(rType(`CPU_FN_OR, 6, 5, 2));
        emit(rType(`CPU_FN_SLT, 7, 1, 6));
        emit(iType(`CPU_OP_ADDI, 8, 0, -4));
        emit(rType(`CPU_FN_SLT, 9, 8, 1));
        emit(rType(`CPU_FN_ADD, 0, 1, 1));
        emit(rType(`CPU_FN_ADD, 10, 9, 8));
        runTest("forwarding");

        // Load-use stalls and stores of forwarded values
        prog.delete();
        emit(iType(`CPU_OP_ADDI, 1, 0, 20));
        emit(iType(`CPU_OP_ADDI, 2, 0, 7));
        emit(iType(`CPU_OP_SW, 2, 1, 0));
        emit(iType(`CPU_OP_LW, 3, 1, 0));
        emit(rType(`CPU_FN_ADD, 4, 3, 2));
        emit(iType(`CPU_OP_SW, 4, 1, 1));
        emit(iType(`CPU_OP_LW, 5, 1, 1));
        emit(iType(`CPU_OP_SW, 5, 1, 2));
        emit(iType(`CPU_OP_LW, 6, 1, 2));
        emit(iType(`CPU_OP_ADDI, 7, 6, 1));
        runTest("load-store");

        // Taken, not taken and a short countdown loop
        prog.delete();
        emit(iType(`CPU_OP_ADDI, 1, 0, 3));
        emit(iType(`CPU_OP_ADDI, 2, 0, 3));
        emit(iType(`CPU_OP_BEQ, 2, 1, 2));
        emit(iType(`CPU_OP_ADDI, 3, 0, 99));
        emit(iType(`CPU_OP_SW, 1, 0, 0));
        emit(iType(`CPU_OP_ADDI, 4, 0, 1));
        emit(iType(`CPU_OP_BEQ, 4, 1, 1));
        emit(iType(`CPU_OP_ADDI, 5, 0, 2));
        emit(iType(`CPU_OP_ADDI, 7, 0, 3));
        emit(iType(`CPU_OP_ADDI, 7, 7, -1));
        emit(iType(`CPU_OP_BEQ, 0, 7, 1));
        emit(iType(`CPU_OP_BEQ, 0, 0, -3));
        emit(iType(`CPU_OP_ADDI, 8, 7, 42));
        runTest("branches");

        // Jumps over one or two instructions
        prog.delete();
        emit(iType(`CPU_OP_ADDI, 1, 0, 1));
        emit(jType(4));
        emit(iType(`CPU_OP_ADDI, 2, 0, 55));
        emit(iType(`CPU_OP_ADDI, 3, 0, 66));
        emit(iType(`CPU_OP_ADDI, 4, 1, 10));
        emit(jType(7));
        emit(iType(`CPU_OP_SW, 4, 0, 0));
        emit(iType(`CPU_OP_SW, 4, 0, 3));
        emit(iType(`CPU_OP_LW, 6, 0, 3));
        emit(jType(11));
        emit(iType(`CPU_OP_ADDI, 6, 0, 1));
        emit(rType(`CPU_FN_ADD, 7, 6, 4));
        runTest("jump");

        // Nothing after the halt word may retire
        prog.delete();
        emit(iType(`CPU_OP_ADDI, 1, 0, 1));
        emit(iType(`CPU_OP_ADDI, 2, 1, 1));
        emit(`CPU_HALT_WORD);
        emit(iType(`CPU_OP_ADDI, 3, 0, 3));
        emit(iType(`CPU_OP_SW, 1, 0, 0));
        runTest("halt");

        randomProgram();
        runTest("random");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 passCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tests/cpu_sva.sv ====
module cpu_sva
    import cpu_pkg::*;
(
    input logic     idex,
    input logic     arstN,
    input logic     stall,
    input logic     branchTaken,
    input pc_t      branchTarget,
    input pc_t      pc,
    input fwdSel_t  fwdA,
    input ifIdReg_t ifId,
    input idExReg_t idEx,
    input wbPort_t  writeBack
);

    timeunit 1ns;
    timeprecision 100ps;

    // Load-use stall holds the PC and IF/ID in place
    stallHoldsFetch: assert property (@(posedge idex) disable iff (!arstN)
        stall |=> ($stable(pc) && $stable(ifId)))
        else $error("PC or IF/ID changed during a load-use stall");

    // An EX/MEM source feeding operand A retires as a write of a nonzero register
    noForwardFromZero: assert property (@(posedge idex) disable iff (!arstN)
        (fwdA == fwdExMem) |=> (writeBack.valid && writeBack.dest != '0
            && writeBack.dest == $past(idEx.rs)))
        else $error("operand A forwarded from a source that does not write its register");

    // Taken beq redirects fetch and leaves bubbles in IF/ID and ID/EX
    branchFlushesBoth: assert property (@(posedge idex) disable iff (!arstN)
        branchTaken |=> (pc == $past(branchTarget) && !ifId.valid && !idEx.valid))
        else $error("taken branch did not redirect the PC and flush both stages");

endmodule

// Attached at the top level where the clock and stage registers are visible
bind pipelineCpu cpu_sva uSva (
    .idex(idex), .arstN(arstN), .stall(stall), .branchTaken(branchTaken),
    .branchTarget(branchTarget), .pc(pc), .fwdA(fwdA), .ifId(ifId),
    .idEx(idEx), .writeBack(writeBack)
);
